// File: source/rvPkg.sv
// rvCore shared definitions
// Word and register index types, RV32I opcode and funct3 values,
// and the select codes exchanged between controller and datapath
package rvPkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [6:0]  opcode_t;

    // Supported major opcodes
    localparam opcode_t opLoad     = 7'b0000011;
    localparam opcode_t opStore    = 7'b0100011;
    localparam opcode_t opRtype    = 7'b0110011;
    localparam opcode_t opBranch   = 7'b1100011;
    localparam opcode_t opItypeAlu = 7'b0010011;
    localparam opcode_t opJal      = 7'b1101111;
    localparam opcode_t opJalr     = 7'b1100111;
    localparam opcode_t opLui      = 7'b0110111;

    // funct3 fields
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [2:0] f3LwSw   = 3'b010;

    // ALU operation
    typedef logic [2:0] aluCtrl_t;
    localparam aluCtrl_t aluAdd = 3'b000;
    localparam aluCtrl_t aluSub = 3'b001;
    localparam aluCtrl_t aluAnd = 3'b010;
    localparam aluCtrl_t aluOr  = 3'b011;
    localparam aluCtrl_t aluSlt = 3'b101;

    // Main decoder class handed to the ALU decoder
    typedef logic [1:0] aluOp_t;
    localparam aluOp_t aluOpMemory = 2'b00;
    localparam aluOp_t aluOpBranch = 2'b01;
    localparam aluOp_t aluOpOther  = 2'b10;

    // Immediate formats
    typedef logic [2:0] immSrc_t;
    localparam immSrc_t immI = 3'b000;
    localparam immSrc_t immS = 3'b001;
    localparam immSrc_t immB = 3'b010;
    localparam immSrc_t immJ = 3'b011;
    localparam immSrc_t immU = 3'b100;

    // Writeback source
    typedef logic [1:0] resultSrc_t;
    localparam resultSrc_t resultAlu       = 2'b00;
    localparam resultSrc_t resultMemory    = 2'b01;
    localparam resultSrc_t resultPcPlus4   = 2'b10;
    localparam resultSrc_t resultImmediate = 2'b11;

    // ALU operand source in execute
    typedef logic [1:0] forward_t;
    localparam forward_t fwdFromRegister  = 2'b00;
    localparam forward_t fwdFromWriteback = 2'b01;
    localparam forward_t fwdFromMemory    = 2'b10;

endpackage

// File: source/pipeCtrlIf.sv
// Controller to datapath bundle
// Instruction fields and stage destinations flow up from the datapath,
// decoded controls, forwarding selects and hazard controls flow back
`timescale 1ns/1ps

interface pipeCtrlIf;
    import rvPkg::*;

    // Decode stage fields
    opcode_t    op;
    logic [2:0] funct3;
    logic       funct7b5;
    regAddr_t   rs1D;
    regAddr_t   rs2D;

    // Execute and later stage register indices
    regAddr_t   rs1E;
    regAddr_t   rs2E;
    regAddr_t   rdE;
    logic       zeroE;
    regAddr_t   rdM;
    regAddr_t   rdW;

    // Hazard controls
    logic       stallF;
    logic       stallD;
    logic       flushD;
    logic       flushE;

    // Per-stage controls
    immSrc_t    immSrcD;
    aluCtrl_t   aluControlE;
    logic       aluSrcE;
    logic       pcSrcE;
    forward_t   forwardAE;
    forward_t   forwardBE;
    resultSrc_t resultSrcM;
    resultSrc_t resultSrcW;
    logic       regWriteW;

    modport ctrl (
        input  op, funct3, funct7b5, rs1D, rs2D, rs1E, rs2E, rdE, zeroE, rdM, rdW,
        output stallF, stallD, flushD, flushE, immSrcD, aluControlE, aluSrcE, pcSrcE,
        output forwardAE, forwardBE, resultSrcM, resultSrcW, regWriteW
    );

    modport dp (
        output op, funct3, funct7b5, rs1D, rs2D, rs1E, rs2E, rdE, zeroE, rdM, rdW,
        input  stallF, stallD, flushD, flushE, immSrcD, aluControlE, aluSrcE, pcSrcE,
        input  forwardAE, forwardBE, resultSrcM, resultSrcW, regWriteW
    );

endinterface

// File: source/controller.sv
// Pipeline controller
// Main and ALU decode, control pipeline E/M/W, branch resolution,
// operand forwarding selects and load-use / redirect hazard handling
`timescale 1ns/1ps

module controller (
    input  logic    clk,
    input  logic    reset,
    output logic    memWriteM_o,
    pipeCtrlIf.ctrl ctrl
);
    import rvPkg::*;

    // Decode stage controls
    logic       regWriteD;
    immSrc_t    immSrcD;
    logic       aluSrcD;
    logic       memWriteD;
    resultSrc_t resultSrcD;
    logic       branchD;
    aluOp_t     aluOpD;
    logic       jumpD;
    aluCtrl_t   aluControlD;
    logic       bneD;
    logic       rtypeSubD;

    // Execute stage controls
    logic       regWriteE;
    resultSrc_t resultSrcE;
    logic       memWriteE;
    logic       jumpE;
    logic       branchE;
    logic       bneE;
    aluCtrl_t   aluControlE;
    logic       aluSrcE;

    // Memory and writeback controls
    logic       regWriteM;
    resultSrc_t resultSrcM;
    logic       regWriteW;
    resultSrc_t resultSrcW;

    logic       pcSrcE;
    logic       lwStall;

    // Main decoder, unknown opcodes fall through as a bubble
    always_comb begin
        regWriteD  = 1'b0;
        immSrcD    = immI;
        aluSrcD    = 1'b0;
        memWriteD  = 1'b0;
        resultSrcD = resultAlu;
        branchD    = 1'b0;
        aluOpD     = aluOpMemory;
        jumpD      = 1'b0;
        case (ctrl.op)
            opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = resultMemory;
            end
            opStore: begin
                immSrcD   = immS;
                aluSrcD   = 1'b1;
                memWriteD = 1'b1;
            end
            opRtype: begin
                regWriteD = 1'b1;
                aluOpD    = aluOpOther;
            end
            opBranch: begin
                immSrcD = immB;
                branchD = 1'b1;
                aluOpD  = aluOpBranch;
            end
            opItypeAlu: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluOpD    = aluOpOther;
            end
            opJal: begin
                regWriteD  = 1'b1;
                immSrcD    = immJ;
                resultSrcD = resultPcPlus4;
                jumpD      = 1'b1;
            end
            opJalr: begin
                regWriteD  = 1'b1;
                resultSrcD = resultPcPlus4;
                jumpD      = 1'b1;
            end
            opLui: begin
                regWriteD  = 1'b1;
                immSrcD    = immU;
                resultSrcD = resultImmediate;
            end
            default: ;
        endcase
    end

    // Only R-type carries the subtract bit in funct7
    assign rtypeSubD = ctrl.funct7b5 & ctrl.op[5];

    // ALU decoder
    always_comb begin
        aluControlD = aluAdd;
        case (aluOpD)
            aluOpBranch: aluControlD = aluSub;
            aluOpOther: begin
                case (ctrl.funct3)
                    f3AddSub: aluControlD = rtypeSubD ? aluSub : aluAdd;
                    f3Slt:    aluControlD = aluSlt;
                    f3Or:     aluControlD = aluOr;
                    f3And:    aluControlD = aluAnd;
                    default:  aluControlD = aluAdd;
                endcase
            end
            default: ;
        endcase
    end

    // bne flips the zero test at resolution
    always_comb begin
        case (ctrl.funct3)
            f3Beq:   bneD = 1'b0;
            f3Bne:   bneD = 1'b1;
            default: bneD = 1'b0;
        endcase
    end

    // Execute stage, bubble on flush
    always_ff @(posedge clk) begin
        if (reset || ctrl.flushE) begin
            regWriteE   <= 1'b0;
            resultSrcE  <= resultAlu;
            memWriteE   <= 1'b0;
            jumpE       <= 1'b0;
            branchE     <= 1'b0;
            bneE        <= 1'b0;
            aluControlE <= aluAdd;
            aluSrcE     <= 1'b0;
        end else begin
            regWriteE   <= regWriteD;
            resultSrcE  <= resultSrcD;
            memWriteE   <= memWriteD;
            jumpE       <= jumpD;
            branchE     <= branchD;
            bneE        <= bneD;
            aluControlE <= aluControlD;
            aluSrcE     <= aluSrcD;
        end
    end

    // Memory and writeback stages
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM   <= 1'b0;
            resultSrcM  <= resultAlu;
            memWriteM_o <= 1'b0;
            regWriteW   <= 1'b0;
            resultSrcW  <= resultAlu;
        end else begin
            regWriteM   <= regWriteE;
            resultSrcM  <= resultSrcE;
            memWriteM_o <= memWriteE;
            regWriteW   <= regWriteM;
            resultSrcW  <= resultSrcM;
        end
    end

    // Taken branch or any jump redirects fetch
    assign pcSrcE = (branchE & (ctrl.zeroE ^ bneE)) | jumpE;

    // Memory stage wins over writeback, x0 never forwarded
    function automatic forward_t forwardSel(regAddr_t rs, regAddr_t rdM, logic wrM,
                                            regAddr_t rdW, logic wrW);
        if (wrM && rs == rdM && rs != '0) begin
            return fwdFromMemory;
        end else if (wrW && rs == rdW && rs != '0) begin
            return fwdFromWriteback;
        end
        return fwdFromRegister;
    endfunction

    assign ctrl.forwardAE = forwardSel(ctrl.rs1E, ctrl.rdM, regWriteM, ctrl.rdW, regWriteW);
    assign ctrl.forwardBE = forwardSel(ctrl.rs2E, ctrl.rdM, regWriteM, ctrl.rdW, regWriteW);

    // Load in execute feeding the instruction in decode
    assign lwStall = (resultSrcE == resultMemory) &&
                     (ctrl.rs1D == ctrl.rdE || ctrl.rs2D == ctrl.rdE) &&
                     (ctrl.rdE != '0);

    assign ctrl.stallF      = lwStall;
    assign ctrl.stallD      = lwStall;
    assign ctrl.flushD      = pcSrcE;
    assign ctrl.flushE      = lwStall | pcSrcE;
    assign ctrl.pcSrcE      = pcSrcE;
    assign ctrl.immSrcD     = immSrcD;
    assign ctrl.aluControlE = aluControlE;
    assign ctrl.aluSrcE     = aluSrcE;
    assign ctrl.resultSrcM  = resultSrcM;
    assign ctrl.resultSrcW  = resultSrcW;
    assign ctrl.regWriteW   = regWriteW;

endmodule

// File: source/registerFile.sv
// Integer register file
// 31 writable registers plus hardwired x0, two async reads, one write
// Write lands on the falling edge so decode sees it the same cycle
`timescale 1ns/1ps

module registerFile (
    input  logic            clk,
    input  logic            we_i,
    input  rvPkg::regAddr_t ra1_i,
    input  rvPkg::regAddr_t ra2_i,
    input  rvPkg::regAddr_t wa_i,
    input  rvPkg::word_t    wd_i,
    output rvPkg::word_t    rd1_o,
    output rvPkg::word_t    rd2_o
);
    import rvPkg::*;

    // x0 has no storage
    word_t regs [31:1];

    always_ff @(negedge clk) begin
        if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

// File: source/datapath.sv
// Pipeline datapath
// PC, the F/D, D/E, E/M and M/W registers, immediate extension,
// forwarding muxes, ALU, redirect target and writeback select
`timescale 1ns/1ps

module datapath #(
    parameter rvPkg::word_t resetAddr = '0
) (
    input  logic         clk,
    input  logic         reset,
    pipeCtrlIf.dp        dp,
    output rvPkg::word_t instrAddr_o,
    input  rvPkg::word_t instrData_i,
    output rvPkg::word_t dataAddr_o,
    output rvPkg::word_t dataWData_o,
    input  rvPkg::word_t dataRData_i
);
    import rvPkg::*;

    // Fetch
    word_t    pcF, pcPlus4F, pcNextF;
    // Decode
    word_t    instrD, pcD, pcPlus4D, rd1D, rd2D, immExtD;
    logic     jalrD;
    // Execute
    word_t    rd1E, rd2E, pcE, pcPlus4E, immExtE;
    word_t    srcAE, srcBE, writeDataE, aluResultE, targetBaseE, pcTargetE;
    regAddr_t rs1E, rs2E, rdE;
    logic     jalrE;
    // Memory
    word_t    aluResultM, writeDataM, pcPlus4M, immExtM, fwdValueM;
    regAddr_t rdM;
    // Writeback
    word_t    aluResultW, readDataW, pcPlus4W, immExtW, resultW;
    regAddr_t rdW;

    // PC, held on load-use stall
    assign pcPlus4F = pcF + 32'd4;
    assign pcNextF  = dp.pcSrcE ? pcTargetE : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= resetAddr;
        end else if (!dp.stallF) begin
            pcF <= pcNextF;
        end
    end

    assign instrAddr_o = pcF;

    // Instruction word cleared to a bubble on flush
    always_ff @(posedge clk) begin
        if (reset || dp.flushD) begin
            instrD <= '0;
        end else if (!dp.stallD) begin
            instrD <= instrData_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!dp.stallD) begin
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

    // Field split for the controller
    assign dp.op       = instrD[6:0];
    assign dp.funct3   = instrD[14:12];
    assign dp.funct7b5 = instrD[30];
    assign dp.rs1D     = instrD[19:15];
    assign dp.rs2D     = instrD[24:20];
    assign jalrD       = (instrD[6:0] == opJalr);

    registerFile i_registerFile (
        .clk   (clk),
        .we_i  (dp.regWriteW),
        .ra1_i (instrD[19:15]),
        .ra2_i (instrD[24:20]),
        .wa_i  (rdW),
        .wd_i  (resultW),
        .rd1_o (rd1D),
        .rd2_o (rd2D)
    );

    // Immediate extension
    always_comb begin
        case (dp.immSrcD)
            immI:    immExtD = {{20{instrD[31]}}, instrD[31:20]};
            immS:    immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                instrD[11:8], 1'b0};
            immJ:    immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                instrD[30:21], 1'b0};
            immU:    immExtD = {instrD[31:12], 12'b0};
            default: immExtD = '0;
        endcase
    end

    // Execute register, control bubble comes from the controller side
    always_ff @(posedge clk) begin
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        pcE      <= pcD;
        pcPlus4E <= pcPlus4D;
        immExtE  <= immExtD;
        rs1E     <= instrD[19:15];
        rs2E     <= instrD[24:20];
        rdE      <= instrD[11:7];
        jalrE    <= jalrD;
    end

    assign dp.rs1E = rs1E;
    assign dp.rs2E = rs2E;
    assign dp.rdE  = rdE;

    // Memory stage value as seen by a dependent instruction
    always_comb begin
        case (dp.resultSrcM)
            resultPcPlus4:   fwdValueM = pcPlus4M;
            resultImmediate: fwdValueM = immExtM;
            default:         fwdValueM = aluResultM;
        endcase
    end

    // Operand forwarding
    always_comb begin
        case (dp.forwardAE)
            fwdFromWriteback: srcAE = resultW;
            fwdFromMemory:    srcAE = fwdValueM;
            default:          srcAE = rd1E;
        endcase
        case (dp.forwardBE)
            fwdFromWriteback: writeDataE = resultW;
            fwdFromMemory:    writeDataE = fwdValueM;
            default:          writeDataE = rd2E;
        endcase
    end

    assign srcBE = dp.aluSrcE ? immExtE : writeDataE;

    // ALU
    always_comb begin
        case (dp.aluControlE)
            aluAdd:  aluResultE = srcAE + srcBE;
            aluSub:  aluResultE = srcAE - srcBE;
            aluAnd:  aluResultE = srcAE & srcBE;
            aluOr:   aluResultE = srcAE | srcBE;
            aluSlt:  aluResultE = {31'b0, $signed(srcAE) < $signed(srcBE)};
            default: aluResultE = '0;
        endcase
    end

    assign dp.zeroE = (aluResultE == '0);

    // jalr jumps off rs1, the rest off the PC
    assign targetBaseE = jalrE ? srcAE : pcE;
    assign pcTargetE   = (targetBaseE + immExtE) & ~32'd1;

    // Memory register
    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        immExtM    <= immExtE;
        rdM        <= rdE;
    end

    assign dataAddr_o  = aluResultM;
    assign dataWData_o = writeDataM;
    assign dp.rdM      = rdM;

    // Writeback register
    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        readDataW  <= dataRData_i;
        pcPlus4W   <= pcPlus4M;
        immExtW    <= immExtM;
        rdW        <= rdM;
    end

    assign dp.rdW = rdW;

    always_comb begin
        case (dp.resultSrcW)
            resultMemory:    resultW = readDataW;
            resultPcPlus4:   resultW = pcPlus4W;
            resultImmediate: resultW = immExtW;
            default:         resultW = aluResultW;
        endcase
    end

endmodule

// File: source/rvCore.sv
// rvCore top level
// Five-stage RV32I subset core, controller plus datapath joined by
// the control bundle, with plain instruction and data memory ports
`timescale 1ns/1ps

module rvCore #(
    parameter rvPkg::word_t resetAddr = '0
) (
    input  logic         clk,
    input  logic         reset,
    // Instruction port, data returned same cycle
    output rvPkg::word_t instrAddr_o,
    input  rvPkg::word_t instrData_i,
    // Data port, write at rising edge
    output rvPkg::word_t dataAddr_o,
    output rvPkg::word_t dataWData_o,
    output logic         dataWe_o,
    input  rvPkg::word_t dataRData_i
);

    // Controller to datapath bundle
    pipeCtrlIf ctrlBus ();

    controller i_controller (
        .clk         (clk),
        .reset       (reset),
        .memWriteM_o (dataWe_o),
        .ctrl        (ctrlBus.ctrl)
    );

    datapath #(
        .resetAddr (resetAddr)
    ) i_datapath (
        .clk         (clk),
        .reset       (reset),
        .dp          (ctrlBus.dp),
        .instrAddr_o (instrAddr_o),
        .instrData_i (instrData_i),
        .dataAddr_o  (dataAddr_o),
        .dataWData_o (dataWData_o),
        .dataRData_i (dataRData_i)
    );

endmodule

// File: tb/rvCore_assertions.sv
// Controller hazard and reset assertions
// Bound into every controller instance
`timescale 1ns/1ps

module rvCore_assertions (
    input logic clk,
    input logic reset,
    input logic memWriteM_i,
    input logic stallF_i,
    input logic stallD_i,
    input logic flushE_i,
    input logic pcSrcE_i
);

    // Fetch and decode always hold together
    stallAgree: assert property (@(posedge clk) disable iff (reset) stallF_i == stallD_i)
        else $error("stallF and stallD disagree");

    // Held decode leaves a bubble in execute
    stallFlushes: assert property (@(posedge clk) disable iff (reset) stallD_i |-> flushE_i)
        else $error("stall without execute flush");

    resetNoWrite: assert property (@(posedge clk) reset |=> !memWriteM_i)
        else $error("memory write right after reset");

    pcSrcKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(pcSrcE_i))
        else $error("pcSrcE unknown");

endmodule

bind controller rvCore_assertions i_rvCore_assertions (
    .clk         (clk),
    .reset       (reset),
    .memWriteM_i (memWriteM_o),
    .stallF_i    (ctrl.stallF),
    .stallD_i    (ctrl.stallD),
    .flushE_i    (ctrl.flushE),
    .pcSrcE_i    (ctrl.pcSrcE)
);

// File: tb/rvCoreTb.sv
// rvCore testbench
// Builds a random program, runs an ISA reference model on it and
// compares every store of the core over two reset passes
`timescale 1ns/1ps

module rvCoreTb;
    import rvPkg::*;

    // Nonzero start so the reset address really reaches the PC
    localparam word_t startAddr = 32'h100;
    localparam word_t haltInstr = {20'h0, 5'd0, 7'b1101111};

    logic  clk = 1'b0;
    logic  reset = 1'b1;
    word_t instrAddr, instrData, dataAddr, dataWData, dataRData;
    logic  dataWe;

    // Program image and the test each word belongs to
    word_t instrMem [64];
    int    instrTest [64];
    word_t dataMem [64];
    int    progLen, storeOff, passStores, cycleCount, cycleLimit = 100000;
    word_t rngState = 32'h841c27c9;
    // Expected store sequence of one pass
    word_t expAddr [$];
    word_t expData [$];
    int    expTest [$];
    int    errs [6];
    int    checks [6];
    string testName [6];

    always #50 clk = ~clk;

    rvCore #(.resetAddr(startAddr)) i_rvCore (
        .clk(clk), .reset(reset), .instrAddr_o(instrAddr), .instrData_i(instrData),
        .dataAddr_o(dataAddr), .dataWData_o(dataWData), .dataWe_o(dataWe),
        .dataRData_i(dataRData)
    );

    // Both memories read combinationally
    assign instrData = instrMem[instrAddr[7:2]];
    assign dataRData = dataMem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (!reset && dataWe) dataMem[dataAddr[7:2]] <= dataWData;
    end

    function automatic word_t memFill(int idx);
        return 32'h13579bdf ^ (idx * 4 * 32'h01000193);
    endfunction

    function automatic word_t xorshift();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Instruction encoders
    function automatic word_t encR(logic f7b5, logic [4:0] rs2, rs1, logic [2:0] f3,
                                   logic [4:0] rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, opRtype};
    endfunction

    function automatic word_t encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(logic [11:0] imm, logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, f3LwSw, imm[4:0], opStore};
    endfunction

    function automatic word_t encB(logic [12:0] imm, logic [4:0] rs2, rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic word_t encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    task automatic emit(word_t w, int test);
        instrMem[progLen] = w;
        instrTest[progLen] = test;
        progLen++;
    endtask

    // Each result goes to its own data word
    task automatic emitStore(logic [4:0] rs2, int test);
        emit(encS(storeOff[11:0], rs2, 5'd0), test);
        storeOff += 4;
    endtask

    task automatic buildProgram();
        logic [11:0] imm1;
        logic [2:0]  f3s [4];
        word_t       luiWord;
        f3s = '{f3AddSub, f3Slt, f3Or, f3And};
        imm1 = 12'(xorshift());
        // Test 0 drives both decoders
        emit(encI(imm1, 5'd0, f3AddSub, 5'd1, opItypeAlu), 0);
        emit(encI(imm1 ^ 12'h5a5, 5'd0, f3AddSub, 5'd2, opItypeAlu), 0);
        emit(encR(1'b0, 5'd2, 5'd1, f3AddSub, 5'd3), 0);
        emitStore(5'd3, 0);
        emit(encR(1'b1, 5'd2, 5'd1, f3AddSub, 5'd3), 0);
        emitStore(5'd3, 0);
        for (int k = 1; k < 4; k++) begin
            emit(encR(1'b0, 5'd2, 5'd1, f3s[k], 5'd3), 0);
            emitStore(5'd3, 0);
        end
        // I-type forms with random immediates
        for (int k = 0; k < 4; k++) begin
            emit(encI(12'(xorshift()), 5'd1, f3s[k], 5'd3, opItypeAlu), 0);
            emitStore(5'd3, 0);
        end
        // Test 1 covers distances 1 and 2 and a write to x0
        emit(encR(1'b0, 5'd2, 5'd1, f3AddSub, 5'd4), 1);
        // Both sources one behind
        emit(encR(1'b0, 5'd4, 5'd4, f3AddSub, 5'd5), 1);
        // rs1 two behind and rs2 one behind
        emit(encR(1'b1, 5'd5, 5'd4, f3AddSub, 5'd6), 1);
        emitStore(5'd6, 1);
        emit(encR(1'b0, 5'd6, 5'd5, f3Or, 5'd7), 1);
        emitStore(5'd7, 1);
        // Both sources two behind and then rs1 alone one behind
        emit(encR(1'b0, 5'd7, 5'd7, f3AddSub, 5'd10), 1);
        emit(encR(1'b1, 5'd2, 5'd10, f3AddSub, 5'd10), 1);
        emitStore(5'd10, 1);
        emit(encI(12'(xorshift()), 5'd1, f3AddSub, 5'd0, opItypeAlu), 1);
        emitStore(5'd0, 1);
        // Test 2 uses a load result right away
        emit(encI(12'd0, 5'd0, f3LwSw, 5'd8, opLoad), 2);
        emit(encR(1'b0, 5'd1, 5'd8, f3AddSub, 5'd9), 2);
        emitStore(5'd9, 2);
        // Test 3 wrong-path stores go to a sentinel slot
        emit(encB(13'd8, 5'd1, 5'd1, f3Beq), 3);
        emit(encS(12'd252, 5'd2, 5'd0), 3);
        emitStore(5'd1, 3);
        emit(encB(13'd8, 5'd2, 5'd1, f3Beq), 3);
        emitStore(5'd2, 3);
        emit(encB(13'd8, 5'd2, 5'd1, f3Bne), 3);
        emit(encS(12'd252, 5'd2, 5'd0), 3);
        emitStore(5'd1, 3);
        emit(encB(13'd8, 5'd1, 5'd1, f3Bne), 3);
        emitStore(5'd2, 3);
        // Test 4 covers jal, lui and jalr
        emit(encJ(21'd8, 5'd11), 4);
        emit(encS(12'd252, 5'd2, 5'd0), 4);
        emitStore(5'd11, 4);
        luiWord = xorshift();
        emit({luiWord[31:12], 5'd12, opLui}, 4);
        emitStore(5'd12, 4);
        // Absolute jalr target skips the sentinel after it
        emit(encI(12'(startAddr + (progLen + 3) * 4), 5'd0, f3AddSub, 5'd13, opItypeAlu), 4);
        emit(encI(12'd0, 5'd13, 3'b000, 5'd14, opJalr), 4);
        emit(encS(12'd252, 5'd2, 5'd0), 4);
        emitStore(5'd14, 4);
        emit(haltInstr, 4);
    endtask

    // ISA reference model stepping one instruction at a time up to the halt loop
    function automatic void runReference();
        word_t r [32];
        word_t m [64];
        word_t pc, ins, a, b, immI, immS, immB, immJ, res, nextPc;
        logic  wr;
        for (int k = 0; k < 32; k++) r[k] = '0;
        for (int k = 0; k < 64; k++) m[k] = memFill(k);
        pc = startAddr;
        for (int step = 0; step < 500; step++) begin
            ins = instrMem[pc[7:2]];
            if (ins == haltInstr) break;
            a = r[ins[19:15]];
            b = r[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            nextPc = pc + 4;
            wr = 1'b1;
            res = '0;
            if (ins[6:0] == opItypeAlu) b = immI;
            case (ins[6:0])
                opRtype, opItypeAlu: begin
                    case (ins[14:12])
                        3'b000: res = (ins[6:0] == opRtype && ins[30]) ? a - b : a + b;
                        3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b110: res = a | b;
                        default: res = a & b;
                    endcase
                end
                opLoad:  res = m[(a + immI) >> 2 & 63];
                opStore: begin
                    wr = 1'b0;
                    m[(a + immS) >> 2 & 63] = b;
                    expAddr.push_back(a + immS);
                    expData.push_back(b);
                    expTest.push_back(instrTest[pc[7:2]]);
                end
                opBranch: begin
                    wr = 1'b0;
                    if ((ins[14:12] == f3Bne) ? (a != b) : (a == b)) nextPc = pc + immB;
                end
                opJal: begin
                    res = pc + 4;
                    nextPc = pc + immJ;
                end
                opJalr: begin
                    res = pc + 4;
                    nextPc = (a + immI) & ~32'd1;
                end
                opLui:   res = {ins[31:12], 12'b0};
                default: wr = 1'b0;
            endcase
            // x0 stays zero
            if (wr && ins[11:7] != 0) r[ins[11:7]] = res;
            pc = nextPc;
        end
    endfunction

    // Store compare sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            passStores = 0;
        end else if (dataWe === 1'b1) begin
            if (passStores >= expAddr.size()) begin
                $display("Unexpected store beyond the expected sequence at %h", dataAddr);
                errs[5]++;
            end else begin
                checks[expTest[passStores]]++;
                if (dataAddr !== expAddr[passStores]) begin
                    $display("CHECK FAILED %s addr: expected %h actual %h",
                             testName[expTest[passStores]], expAddr[passStores], dataAddr);
                    errs[expTest[passStores]]++;
                end
                if (dataWData !== expData[passStores]) begin
                    $display("CHECK FAILED %s data: expected %h actual %h",
                             testName[expTest[passStores]], expData[passStores], dataWData);
                    errs[expTest[passStores]]++;
                end
            end
            passStores++;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, store sequence never completed", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic applyReset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    // Fetch sits at the reset address and no store may leave the core
    // before the first one can complete
    task automatic checkQuietStart();
        @(negedge clk);
        checks[5]++;
        if (instrAddr !== startAddr) begin
            $display("CHECK FAILED reset: expected instrAddr %h actual %h",
                     startAddr, instrAddr);
            errs[5]++;
        end
        repeat (4) begin
            checks[5]++;
            if (dataWe !== 1'b0) begin
                $display("CHECK FAILED reset: expected dataWe 0 actual %b", dataWe);
                errs[5]++;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int total;
        int totalChecks;
        testName = '{"alu", "forwarding", "loadUse", "branch", "jumpLui", "reset"};
        for (int k = 0; k < 64; k++) begin
            dataMem[k] = memFill(k);
            instrMem[k] = '0;
            instrTest[k] = 4;
        end
        buildProgram();
        runReference();
        // Two passes over the program
        cycleLimit = 2 * (4 * progLen + 100);
        cycleCount = 0;
        applyReset();
        checkQuietStart();
        // Second reset lands halfway through the first pass
        while (passStores < expAddr.size() / 2) @(posedge clk);
        applyReset();
        checkQuietStart();
        while (passStores < expAddr.size()) @(posedge clk);
        repeat (20) @(posedge clk);
        checks[5]++;
        if (passStores != expAddr.size()) begin
            $display("CHECK FAILED reset: expected %0d stores actual %0d",
                     expAddr.size(), passStores);
            errs[5]++;
        end
        total = 0;
        totalChecks = 0;
        for (int k = 0; k < 6; k++) begin
            $display("%s: %0d checks, %0d errors", testName[k], checks[k], errs[k]);
            total += errs[k];
            totalChecks += checks[k];
        end
        $display("tests 6, checks %0d, errors %0d", totalChecks, total);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
source/rvPkg.sv
source/pipeCtrlIf.sv
source/controller.sv
source/registerFile.sv
source/datapath.sv
source/rvCore.sv
tb/rvCore_assertions.sv
tb/rvCoreTb.sv
